// File: stream_pkg.sv
// shared widths and types for the four-input stream multiplexer
// beat struct, port select and mask types, frame state enum

package stream_pkg;

    // number of stream inputs
    localparam int port_count = 4;

    // one data byte per beat
    localparam int data_width = 8;

    // bits needed to index an input port
    localparam int sel_width = $clog2(port_count);

    // payload of a single beat
    typedef logic [data_width-1:0] stream_data_t;

    // index of an input port
    typedef logic [sel_width-1:0] port_sel_t;

    // one bit per input, used for valid, ready and last vectors
    typedef logic [port_count-1:0] port_mask_t;

    // everything that travels with a beat
    // user set on any beat marks the whole frame as bad
    typedef struct packed {
        stream_data_t data;
        logic         last;
        logic         user;
    } stream_beat_t;

    // frame tracking in the frame mux
    typedef enum logic {
        frame_idle,
        frame_active
    } frame_state_e;

endpackage

// File: stream_frame_mux.sv
// frame-aware input selection for the stream multiplexer
// latches select at frame start and holds it until the last beat passes

module stream_frame_mux
    import stream_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  stream_beat_t in_beat [port_count],
    input  port_mask_t   in_valid,
    output port_mask_t   in_ready,

    input  logic         enable,
    input  port_sel_t    select,

    input  logic         ready_early,
    output stream_beat_t mid_beat,
    output logic         mid_valid
);

    frame_state_e state_q;
    frame_state_e state_d;
    port_sel_t    sel_q;
    port_sel_t    sel_d;
    port_mask_t   ready_q;
    port_mask_t   ready_d;

    stream_beat_t cur_beat;
    logic         cur_valid;
    logic         cur_ready;
    logic         cur_xfer;
    logic         frame_done;
    logic         frame_free;
    logic         sel_pending;
    logic         frame_start;

    assign in_ready = ready_q;

    // view of the latched input
    assign cur_beat  = in_beat[sel_q];
    assign cur_valid = in_valid[sel_q];
    assign cur_ready = ready_q[sel_q];
    assign cur_xfer  = cur_valid && cur_ready;

    // last beat of the current frame moves on this edge
    assign frame_done = (state_q == frame_active) && cur_xfer && cur_beat.last;

    // free now, or free right after this edge
    assign frame_free = (state_q == frame_idle) || frame_done;

    // on the closing edge the latched port's valid still belongs to the
    // beat being consumed, so it cannot open a new frame there
    assign sel_pending = in_valid[select] && !(frame_done && (select == sel_q));

    assign frame_start = frame_free && enable && sel_pending;

    // next frame state and latched port
    always_comb begin
        state_d = state_q;
        sel_d   = sel_q;

        if (frame_done) begin
            state_d = frame_idle;
        end

        if (frame_start) begin
            state_d = frame_active;
            sel_d   = select;
        end
    end

    // one-hot ready for the port that owns the next cycle
    always_comb begin
        ready_d = '0;
        if (ready_early && (state_d == frame_active)) begin
            ready_d[sel_d] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= frame_idle;
            sel_q   <= '0;
            ready_q <= '0;
        end else begin
            state_q <= state_d;
            sel_q   <= sel_d;
            ready_q <= ready_d;
        end
    end

    // beat forwarded to the skid register
    assign mid_beat = cur_beat;

    // only accepted beats of an open frame count
    assign mid_valid = (state_q == frame_active) && cur_xfer;

endmodule

// File: stream_skid_reg.sv
// two-entry skid register on the mux output
// output register plus a spare that catches the beat in flight on a stall

module stream_skid_reg
    import stream_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  stream_beat_t mid_beat,
    input  logic         mid_valid,
    output logic         ready_early,

    output stream_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    // payload registers
    stream_beat_t out_q;
    stream_beat_t spare_q;

    // control state
    logic out_valid_q;
    logic out_valid_d;
    logic spare_valid_q;
    logic spare_valid_d;
    logic ready_q;

    // datapath moves for this cycle
    logic load_out_mid;
    logic load_spare_mid;
    logic load_out_spare;

    // accept next cycle if the sink takes the current beat, or if the
    // spare stays empty and the output register is not blocked by a new beat
    assign ready_early = out_ready || (!spare_valid_q && (!out_valid_q || !mid_valid));

    always_comb begin
        out_valid_d    = out_valid_q;
        spare_valid_d  = spare_valid_q;
        load_out_mid   = 1'b0;
        load_spare_mid = 1'b0;
        load_out_spare = 1'b0;

        if (ready_q) begin
            // a beat may arrive this cycle
            if (out_ready || !out_valid_q) begin
                out_valid_d  = mid_valid;
                load_out_mid = 1'b1;
            end else begin
                // output stalled, park the beat
                spare_valid_d  = mid_valid;
                load_spare_mid = 1'b1;
            end
        end else if (out_ready) begin
            // upstream held off, drain the spare first
            out_valid_d    = spare_valid_q;
            spare_valid_d  = 1'b0;
            load_out_spare = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q   <= 1'b0;
            spare_valid_q <= 1'b0;
            ready_q       <= 1'b0;
        end else begin
            out_valid_q   <= out_valid_d;
            spare_valid_q <= spare_valid_d;
            ready_q       <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_mid) begin
            out_q <= mid_beat;
        end else if (load_out_spare) begin
            out_q <= spare_q;
        end

        if (load_spare_mid) begin
            spare_q <= mid_beat;
        end
    end

    assign out_beat  = out_q;
    assign out_valid = out_valid_q;

endmodule

// File: stream_mux_top.sv
// top level of the stream multiplexer
// frame mux feeding the output skid register

module stream_mux_top
    import stream_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  stream_beat_t in_beat [port_count],
    input  port_mask_t   in_valid,
    output port_mask_t   in_ready,

    input  logic         enable,
    input  port_sel_t    select,

    output stream_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    // link between the frame mux and the skid register
    stream_beat_t mid_beat;
    logic         mid_valid;
    logic         ready_early;

    stream_frame_mux u_frame_mux (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .enable      (enable),
        .select      (select),
        .ready_early (ready_early),
        .mid_beat    (mid_beat),
        .mid_valid   (mid_valid)
    );

    stream_skid_reg u_skid_reg (
        .clk         (clk),
        .rst         (rst),
        .mid_beat    (mid_beat),
        .mid_valid   (mid_valid),
        .ready_early (ready_early),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

// File: stream_mux_props.sv
// bound assertions for the stream multiplexer top level
// one-hot ready, held output under stall, quiet ports after reset

module stream_mux_props
    import stream_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input port_mask_t   in_ready,
    input stream_beat_t out_beat,
    input logic         out_valid,
    input logic         out_ready
);

    // only the latched port may be ready
    ready_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot0(in_ready))
        else $error("in_ready has more than one bit set");

    // a stalled beat stays on the output
    out_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("out_beat changed while the sink stalled");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !out_valid && in_ready == '0)
        else $error("in_ready or out_valid high right after reset");

endmodule

bind stream_mux_top stream_mux_props u_props (.*);

// File: tb_stream_mux.sv
// testbench for the frame-aware stream multiplexer
// frame table sources, LFSR stalls, output scoreboard and run limit

module tb_stream_mux
    import stream_pkg::*;
();

    localparam int  num_frames  = 11;
    localparam int  src_depth   = 16;
    localparam time drive_delay = 10;

    // port, frame length, enable level, select change mid-frame
    typedef struct packed {
        port_sel_t  port;
        logic [3:0] len;
        logic       enable;
        logic       sel_change;
    } frame_entry_t;

    logic         clk;
    logic         rst;
    stream_beat_t in_beat [port_count];
    port_mask_t   in_valid;
    port_mask_t   in_ready;
    logic         enable;
    port_sel_t    select;
    stream_beat_t out_beat;
    logic         out_valid;
    logic         out_ready;

    frame_entry_t frame_table [num_frames];
    stream_beat_t src_mem [port_count][src_depth];
    int           src_head [port_count];
    int           src_tail [port_count];
    stream_beat_t exp_q [$];

    logic [31:0]  lfsr_state = 32'h9f5c_2765;
    int           cycles = 0;
    int           cycle_limit = 100;
    int           xfer_entry = 0;
    int           xfer_left = 0;
    logic         hold_check = 1'b0;
    logic         stall_seen = 1'b0;
    stream_beat_t stall_beat;

    stream_mux_top uut (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .enable    (enable),
        .select    (select),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            report_failure($sformatf("timeout after %0d cycles with beats still missing", cycles));
        end
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_beat(input stream_beat_t got, input stream_beat_t exp,
                              input string what);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED at %0t: %s is %h/%b/%b, expected %h/%b/%b",
                $time, what, got.data, got.last, got.user, exp.data, exp.last, exp.user));
        end
    endtask

    task automatic check_mask(input port_mask_t got, input port_mask_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    // queued frame beats first, then idle or decoy beats
    task automatic drive_sources();
        for (int p = 0; p < port_count; p++) begin
            if (src_head[p] != src_tail[p]) begin
                in_beat[p]  = src_mem[p][src_head[p] % src_depth];
                in_valid[p] = 1'b1;
            end else if (port_sel_t'(p) == select) begin
                in_beat[p]  = '0;
                in_valid[p] = 1'b0;
            end else begin
                // decoys carry a high nibble of f, which frame beats never have
                in_beat[p]  = '{data: {4'hf, 2'b10, 2'(p)}, last: 1'b1, user: 1'b1};
                in_valid[p] = 1'b1;
            end
        end
    endtask

    task automatic load_frame(input int e);
        frame_entry_t ent;
        stream_beat_t b;
        ent = frame_table[e];
        for (int k = 0; k < ent.len; k++) begin
            b.data = '0;
            for (int i = 0; i < 7; i++) begin
                b.data = {b.data[6:0], next_bit()};
            end
            b.last = (k == ent.len - 1);
            b.user = next_bit() & next_bit();
            src_mem[ent.port][src_tail[ent.port] % src_depth] = b;
            src_tail[ent.port]++;
            exp_q.push_back(b);
        end
    endtask

    // sample at the falling edge, drive just after the rising edge
    task automatic step();
        port_mask_t fire;
        port_mask_t allowed;
        logic       out_fire;
        @(negedge clk);
        fire     = in_valid & in_ready;
        out_fire = out_valid && out_ready;
        allowed  = '0;
        if (xfer_entry < num_frames) begin
            allowed[frame_table[xfer_entry].port] = 1'b1;
        end
        check_mask(in_ready & ~allowed, '0, "in_ready outside the frame port");
        if (hold_check) begin
            check_mask(in_ready, '0, "in_ready with enable low");
            check_flag(out_valid, 1'b0, "out_valid with enable low");
        end
        if (stall_seen) begin
            check_flag(out_valid, 1'b1, "out_valid after a stall");
            check_beat(out_beat, stall_beat, "stalled out_beat");
        end
        stall_seen = out_valid && !out_ready;
        stall_beat = out_beat;
        if (out_fire && exp_q.size() == 0) begin
            report_failure($sformatf("CHECK FAILED at %0t: extra output beat %h", $time,
                out_beat.data));
        end else if (out_fire) begin
            check_beat(out_beat, exp_q.pop_front(), "output beat");
        end
        @(posedge clk);
        #(drive_delay);
        for (int p = 0; p < port_count; p++) begin
            if (fire[p]) begin
                src_head[p]++;
            end
        end
        if (fire != '0) begin
            xfer_left--;
            if (xfer_left == 0) begin
                xfer_entry++;
                if (xfer_entry < num_frames) begin
                    xfer_left = frame_table[xfer_entry].len;
                end
            end
        end
        // sink stalls about one cycle in four
        out_ready = !(next_bit() & next_bit());
        drive_sources();
    endtask

    initial begin
        int total_beats;
        bit preloaded;
        rst       = 1'b1;
        enable    = 1'b0;
        select    = '0;
        in_valid  = '0;
        out_ready = 1'b0;
        for (int p = 0; p < port_count; p++) begin
            in_beat[p]  = '0;
            src_head[p] = 0;
            src_tail[p] = 0;
        end
        frame_table[0]  = {2'd0, 4'd3, 1'b1, 1'b0};
        frame_table[1]  = {2'd2, 4'd1, 1'b1, 1'b0};
        frame_table[2]  = {2'd1, 4'd5, 1'b1, 1'b1};
        frame_table[3]  = {2'd3, 4'd4, 1'b1, 1'b0};
        frame_table[4]  = {2'd2, 4'd3, 1'b0, 1'b0};
        frame_table[5]  = {2'd0, 4'd6, 1'b1, 1'b1};
        frame_table[6]  = {2'd1, 4'd2, 1'b1, 1'b1};
        frame_table[7]  = {2'd3, 4'd7, 1'b1, 1'b0};
        frame_table[8]  = {2'd3, 4'd2, 1'b1, 1'b0};
        frame_table[9]  = {2'd1, 4'd8, 1'b0, 1'b0};
        frame_table[10] = {2'd2, 4'd4, 1'b1, 1'b0};
        total_beats = 0;
        for (int e = 0; e < num_frames; e++) begin
            total_beats += frame_table[e].len;
        end
        cycle_limit = 8 * total_beats + 100;
        xfer_left   = frame_table[0].len;

        repeat (4) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_mask(in_ready, '0, "in_ready after reset");
            check_flag(out_valid, 1'b0, "out_valid after reset");
        end
        @(posedge clk);
        #(drive_delay);
        out_ready = 1'b1;
        preloaded = 1'b0;

        for (int e = 0; e < num_frames; e++) begin
            if (!preloaded) begin
                // an enable-low entry starts from an empty output
                while (!frame_table[e].enable && exp_q.size() != 0) begin
                    step();
                end
                load_frame(e);
                select = frame_table[e].port;
                enable = frame_table[e].enable;
                drive_sources();
            end
            preloaded = 1'b0;
            if (!frame_table[e].enable) begin
                hold_check = 1'b1;
                repeat (6) step();
                hold_check = 1'b0;
                enable     = 1'b1;
            end
            while (xfer_entry == e) begin
                step();
                // move select to the next frame's port once this frame is under way
                if (frame_table[e].sel_change && !preloaded && xfer_entry == e
                        && e + 1 < num_frames) begin
                    load_frame(e + 1);
                    select    = frame_table[e + 1].port;
                    preloaded = 1'b1;
                    drive_sources();
                end
            end
        end

        while (exp_q.size() != 0) begin
            step();
        end
        repeat (3) step();
        $display("sim passed");
        $finish;
    end

endmodule

// File: src.f
stream_pkg.sv
stream_frame_mux.sv
stream_skid_reg.sv
stream_mux_top.sv
stream_mux_props.sv
tb_stream_mux.sv

// File: Bender.yml
package:
  name: stream_mux

sources:
  - stream_pkg.sv
  - stream_frame_mux.sv
  - stream_skid_reg.sv
  - stream_mux_top.sv
  - target: test
    files:
      - stream_mux_props.sv
      - tb_stream_mux.sv
